// ==== Makefile ====
# Verilator flow for the two-window video mixer

SIM := obj_dir/video_mixer_sim
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f video_mixer.f --top-module video_mixer_tb

$(SIM): video_mixer.f common/*.sv common/*.svh rtl/*.sv overlay/*.sv tb/*.sv
	verilator --binary --timing --assert -f video_mixer.f --top-module video_mixer_tb \
		-o video_mixer_sim

sim: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // field order as the camera sends it
    typedef struct packed {
        logic [4:0] b;
        logic [5:0] g;
        logic [4:0] r;
    } bgr565_t;

    typedef union packed {
        rgb565_t rgb;
        bgr565_t bgr;
    } pix565_u;

    // eight vertical bars, left to right
    localparam rgb565_t [0:7] BAR_COLORS = '{
        16'hffff,  // white
        16'hffe0,  // yellow
        16'h07ff,  // cyan
        16'h07e0,  // green
        16'hf81f,  // magenta
        16'hf800,  // red
        16'h001f,  // blue
        16'h0000   // black
    };

endpackage

`default_nettype wire

// ==== common/video_defines.svh ====
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

////////////////////////////////////////
// raster timing
////////////////////////////////////////
`define VM_H_ACTIVE      32  // active pixels per line
`define VM_H_TOTAL       40  // pixels per line incl. blanking
`define VM_H_SYNC_START  34
`define VM_H_SYNC_END    37  // first column after hs
`define VM_V_ACTIVE      12  // active lines per frame
`define VM_V_TOTAL       14
`define VM_V_SYNC_LINE   13  // vs high for this whole line

////////////////////////////////////////
// overlay windows and buffering
////////////////////////////////////////
`define VM_WIN0_LEFT     4   // camera window
`define VM_WIN0_TOP      2
`define VM_WIN0_WIDTH    8
`define VM_WIN0_HEIGHT   4
`define VM_WIN1_LEFT     18  // video-input window
`define VM_WIN1_TOP      6
`define VM_WIN1_WIDTH    8
`define VM_WIN1_HEIGHT   4
`define VM_FIFO_DEPTH    64  // power of two

`endif

// ==== common/video_if.sv ====
`default_nettype none

// one raster stream, all signals change on core_clk
interface video_if;

    logic               hs;
    logic               vs;
    logic               de;   // active pixel
    pixel_pkg::rgb565_t pix;

    modport src (output hs, output vs, output de, output pix);
    modport snk (input hs, input vs, input de, input pix);

endinterface

`default_nettype wire

// ==== common/video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

    localparam int COORD_W = 12;  // enough for 4k rasters

    // column or line number, also used for window geometry
    typedef logic [COORD_W-1:0] coord_t;

endpackage

`default_nettype wire

// ==== overlay/rect_overlay.sv ====
`default_nettype none

module rect_overlay #(
    parameter video_timing_pkg::coord_t LEFT   = 12'd0,
    parameter video_timing_pkg::coord_t TOP    = 12'd0,
    parameter video_timing_pkg::coord_t WIDTH  = 12'd8,
    parameter video_timing_pkg::coord_t HEIGHT = 12'd4
) (
    input  wire logic               core_clk,
    input  wire logic               rst_n_i,
    video_if.snk                    vid_i,
    video_if.src                    vid_o,
    output logic                    pop_o,
    input  wire pixel_pkg::rgb565_t fifo_data_i,
    input  wire logic               fifo_empty_i
);

    localparam video_timing_pkg::coord_t RIGHT  = LEFT + WIDTH;   // first column past window
    localparam video_timing_pkg::coord_t BOTTOM = TOP + HEIGHT;

    video_timing_pkg::coord_t col_cnt;   // column of the incoming pixel
    video_timing_pkg::coord_t line_cnt;  // active line of the incoming pixel
    logic                     in_win;

    ////////////////////////////////////////
    // position tracking from de and vs
    ////////////////////////////////////////
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end
        else
        begin
            col_cnt <= vid_i.de ? col_cnt + 1'b1 : '0;
            if (vid_i.vs)
                line_cnt <= '0;
            else if (!vid_i.de && col_cnt != '0)
                line_cnt <= line_cnt + 1'b1;  // end of an active run
        end
    end

    assign in_win = vid_i.de
                 && (col_cnt >= LEFT) && (col_cnt < RIGHT)
                 && (line_cnt >= TOP) && (line_cnt < BOTTOM);

    // an empty buffer leaves the background visible
    assign pop_o = in_win && !fifo_empty_i;

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            vid_o.hs <= 1'b0;
            vid_o.vs <= 1'b0;
            vid_o.de <= 1'b0;
        end
        else
        begin
            vid_o.hs <= vid_i.hs;
            vid_o.vs <= vid_i.vs;
            vid_o.de <= vid_i.de;
        end
    end

    always_ff @(posedge core_clk)
    begin
        vid_o.pix <= pop_o ? fifo_data_i : vid_i.pix;
    end

endmodule

`default_nettype wire

// ==== rtl/cam_byte_pack.sv ====
`default_nettype none

module cam_byte_pack (
    input  wire logic         core_clk,
    input  wire logic         rst_n_i,
    input  wire logic [7:0]   data_i,
    input  wire logic         href_i,
    input  wire logic         vsync_i,
    output pixel_pkg::rgb565_t word_o,
    output logic              word_vld_o,
    output logic              vsync_o
);

    logic [7:0]         data_q;   // camera byte, one cycle late
    logic               href_q;
    logic               vsync_q;
    logic               phase_q;  // 0: high byte, 1: low byte
    logic [7:0]         hi_q;
    pixel_pkg::pix565_u cam_u;

    // the byte pair arrives in blue, green, red order
    assign cam_u.bgr = {hi_q, data_q};

    ////////////////////////////////////////
    // input capture and byte phase
    ////////////////////////////////////////
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            href_q     <= 1'b0;
            vsync_q    <= 1'b0;
            vsync_o    <= 1'b0;
            phase_q    <= 1'b0;
            word_vld_o <= 1'b0;
        end
        else
        begin
            href_q     <= href_i;
            vsync_q    <= vsync_i;
            vsync_o    <= vsync_q;             // lines up with word_vld_o
            phase_q    <= href_q & ~phase_q;   // gap restarts the pairing
            word_vld_o <= href_q & phase_q;
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_q <= data_i;
        if (href_q && !phase_q)
            hi_q <= data_q;
        if (href_q && phase_q)
            word_o <= '{r: cam_u.bgr.r, g: cam_u.bgr.g, b: cam_u.bgr.b};
    end

endmodule

`default_nettype wire

// ==== rtl/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo #(
    parameter int DEPTH = 64  // must be a power of two
) (
    input  wire logic               core_clk,
    input  wire logic               rst_n_i,
    input  wire logic               fsync_i,
    input  wire logic               wr_i,
    input  wire pixel_pkg::rgb565_t wr_data_i,
    input  wire logic               pop_i,
    output pixel_pkg::rgb565_t      rd_data_o,
    output logic                    empty_o
);

    localparam int              ADDR_W   = $clog2(DEPTH);
    localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W + 1)'(DEPTH);

    pixel_pkg::rgb565_t mem [DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;   // wraps on its own
    logic [ADDR_W-1:0]  rd_ptr;
    logic [ADDR_W:0]    count;
    logic               fsync_q;
    logic               gate_q;   // open after first frame start
    logic               wr_ok;

    assign wr_ok = wr_i && gate_q && (count != FULL_CNT);  // full drops the word

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            fsync_q <= 1'b0;
            gate_q  <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end
        else
        begin
            fsync_q <= fsync_i;
            if (fsync_i && !fsync_q)
                gate_q <= 1'b1;
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (wr_ok)
            mem[wr_ptr] <= wr_data_i;
    end

    assign rd_data_o = mem[rd_ptr];  // head word, show-ahead
    assign empty_o   = (count == '0);

endmodule

`default_nettype wire

// ==== rtl/raster_gen.sv ====
`default_nettype none

`include "video_defines.svh"

module raster_gen (
    input wire logic core_clk,
    input wire logic rst_n_i,
    video_if.src     vid_o
);

    localparam video_timing_pkg::coord_t H_LAST   = `VM_H_TOTAL - 1;
    localparam video_timing_pkg::coord_t V_LAST   = `VM_V_TOTAL - 1;
    localparam video_timing_pkg::coord_t H_ACT    = `VM_H_ACTIVE;
    localparam video_timing_pkg::coord_t V_ACT    = `VM_V_ACTIVE;
    localparam video_timing_pkg::coord_t HS_START = `VM_H_SYNC_START;
    localparam video_timing_pkg::coord_t HS_END   = `VM_H_SYNC_END;
    localparam video_timing_pkg::coord_t VS_LINE  = `VM_V_SYNC_LINE;
    localparam video_timing_pkg::coord_t BAR_W    = `VM_H_ACTIVE / 8;

    video_timing_pkg::coord_t h_cnt;
    video_timing_pkg::coord_t v_cnt;
    video_timing_pkg::coord_t bar_col;
    logic [2:0]               bar_idx;
    logic                     de_d;
    logic                     hs_d;
    logic                     vs_d;

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == H_LAST)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    assign de_d    = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign hs_d    = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vs_d    = (v_cnt == VS_LINE);   // whole line
    assign bar_col = h_cnt / BAR_W;
    assign bar_idx = bar_col[2:0];

    ////////////////////////////////////////
    // registered stream
    ////////////////////////////////////////
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            vid_o.hs <= 1'b0;
            vid_o.vs <= 1'b0;
            vid_o.de <= 1'b0;
        end
        else
        begin
            vid_o.hs <= hs_d;
            vid_o.vs <= vs_d;
            vid_o.de <= de_d;
        end
    end

    always_ff @(posedge core_clk)
    begin
        vid_o.pix <= de_d ? pixel_pkg::BAR_COLORS[bar_idx] : '0;  // black in blanking
    end

endmodule

`default_nettype wire

// ==== rtl/video_mixer_top.sv ====
`default_nettype none

`include "video_defines.svh"

module video_mixer_top (
    input  wire logic       core_clk,
    input  wire logic       rst_n_i,
    input  wire logic [7:0] cam_data_i,
    input  wire logic       cam_href_i,
    input  wire logic       cam_vsync_i,
    input  wire logic       vin_de_i,
    input  wire logic       vin_vs_i,
    input  wire logic [7:0] vin_r_i,
    input  wire logic [7:0] vin_g_i,
    input  wire logic [7:0] vin_b_i,
    output logic            hs_o,
    output logic            vs_o,
    output logic            de_o,
    output logic [7:0]      r_o,
    output logic [7:0]      g_o,
    output logic [7:0]      b_o
);

    pixel_pkg::rgb565_t cam_word;
    pixel_pkg::rgb565_t cam_head;
    pixel_pkg::rgb565_t vin_word;
    pixel_pkg::rgb565_t vin_head;
    logic               cam_word_vld;
    logic               cam_vsync;
    logic               cam_pop;
    logic               cam_empty;
    logic               vin_pop;
    logic               vin_empty;

    video_if vid_bar ();  // colour bars
    video_if vid_mid ();  // after camera window
    video_if vid_out ();  // after video-input window

    ////////////////////////////////////////
    // sources into the buffers
    ////////////////////////////////////////
    cam_byte_pack cam_byte_pack_m0 (
        .core_clk   (core_clk),
        .rst_n_i    (rst_n_i),
        .data_i     (cam_data_i),
        .href_i     (cam_href_i),
        .vsync_i    (cam_vsync_i),
        .word_o     (cam_word),
        .word_vld_o (cam_word_vld),
        .vsync_o    (cam_vsync)
    );

    pixel_fifo #(.DEPTH(`VM_FIFO_DEPTH)) cam_fifo_m0 (
        .core_clk  (core_clk),
        .rst_n_i   (rst_n_i),
        .fsync_i   (cam_vsync),
        .wr_i      (cam_word_vld),
        .wr_data_i (cam_word),
        .pop_i     (cam_pop),
        .rd_data_o (cam_head),
        .empty_o   (cam_empty)
    );

    // keep the top bits of each colour
    assign vin_word = '{r: vin_r_i[7:3], g: vin_g_i[7:2], b: vin_b_i[7:3]};

    pixel_fifo #(.DEPTH(`VM_FIFO_DEPTH)) vin_fifo_m0 (
        .core_clk  (core_clk),
        .rst_n_i   (rst_n_i),
        .fsync_i   (vin_vs_i),
        .wr_i      (vin_de_i),
        .wr_data_i (vin_word),
        .pop_i     (vin_pop),
        .rd_data_o (vin_head),
        .empty_o   (vin_empty)
    );

    ////////////////////////////////////////
    // raster and overlay chain
    ////////////////////////////////////////
    raster_gen raster_gen_m0 (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .vid_o    (vid_bar.src)
    );

    rect_overlay #(
        .LEFT   (`VM_WIN0_LEFT),
        .TOP    (`VM_WIN0_TOP),
        .WIDTH  (`VM_WIN0_WIDTH),
        .HEIGHT (`VM_WIN0_HEIGHT)
    ) rect_overlay_m0 (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .vid_i        (vid_bar.snk),
        .vid_o        (vid_mid.src),
        .pop_o        (cam_pop),
        .fifo_data_i  (cam_head),
        .fifo_empty_i (cam_empty)
    );

    rect_overlay #(
        .LEFT   (`VM_WIN1_LEFT),
        .TOP    (`VM_WIN1_TOP),
        .WIDTH  (`VM_WIN1_WIDTH),
        .HEIGHT (`VM_WIN1_HEIGHT)
    ) rect_overlay_m1 (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .vid_i        (vid_mid.snk),
        .vid_o        (vid_out.src),
        .pop_o        (vin_pop),
        .fifo_data_i  (vin_head),
        .fifo_empty_i (vin_empty)
    );

    assign hs_o = vid_out.hs;
    assign vs_o = vid_out.vs;
    assign de_o = vid_out.de;
    assign r_o  = {vid_out.pix.r, 3'b000};  // zero low bits
    assign g_o  = {vid_out.pix.g, 2'b00};
    assign b_o  = {vid_out.pix.b, 3'b000};

endmodule

`default_nettype wire

// ==== tb/video_mixer_sva.sv ====
`default_nettype none

module video_mixer_sva (
    input wire logic core_clk,
    input wire logic rst_n_i,
    input wire logic in_hs_i,
    input wire logic in_vs_i,
    input wire logic in_de_i,
    input wire logic out_hs_i,
    input wire logic out_vs_i,
    input wire logic out_de_i,
    input wire logic pop_i,
    input wire logic fifo_empty_i
);

    logic de_seen;  // input de was high since reset

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            de_seen <= 1'b0;
        else if (in_de_i)
            de_seen <= 1'b1;
    end

    ////////////////////////////////////////
    // stream timing through one stage
    ////////////////////////////////////////
    sync_delay_a : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        $past(rst_n_i) |->
            ({out_hs_i, out_vs_i, out_de_i} == $past({in_hs_i, in_vs_i, in_de_i}))
    ) else $error("overlay hs/vs/de is not its input delayed by one cycle");

    pop_a : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        pop_i |-> (in_de_i && !fifo_empty_i)
    ) else $error("overlay pops outside an active pixel or from an empty FIFO");

    de_start_a : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        out_de_i |-> de_seen
    ) else $error("overlay output de is high before any input de");

endmodule

`default_nettype wire

// ==== tb/video_mixer_tb.sv ====
`default_nettype none

`include "video_defines.svh"

module video_mixer_tb;

    localparam int N_ENTRIES       = 32;
    localparam int FRAME_CYCLES    = `VM_H_TOTAL * `VM_V_TOTAL;
    localparam int LOAD_CYCLES     = 4 * N_ENTRIES;  // camera feed incl. gaps
    localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES + LOAD_CYCLES;
    localparam int BAR_W           = `VM_H_ACTIVE / 8;

    logic        core_clk;
    logic        rst_n_i;
    logic [7:0]  cam_data_i;
    logic        cam_href_i;
    logic        cam_vsync_i;
    logic        vin_de_i;
    logic        vin_vs_i;
    logic [7:0]  vin_r_i;
    logic [7:0]  vin_g_i;
    logic [7:0]  vin_b_i;
    logic        hs_o;
    logic        vs_o;
    logic        de_o;
    logic [7:0]  r_o;
    logic [7:0]  g_o;
    logic [7:0]  b_o;

    logic [7:0]  cam_hi  [N_ENTRIES];  // first byte of a pair
    logic [7:0]  cam_lo  [N_ENTRIES];
    logic [15:0] cam_exp [N_ENTRIES];  // RGB565 after field swap
    logic [23:0] vin_pix [N_ENTRIES];
    logic [15:0] vin_exp [N_ENTRIES];
    integer      seed;

    video_mixer_top video_mixer_top_inst (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .vin_de_i    (vin_de_i),
        .vin_vs_i    (vin_vs_i),
        .vin_r_i     (vin_r_i),
        .vin_g_i     (vin_g_i),
        .vin_b_i     (vin_b_i),
        .hs_o        (hs_o),
        .vs_o        (vs_o),
        .de_o        (de_o),
        .r_o         (r_o),
        .g_o         (g_o),
        .b_o         (b_o)
    );

    bind rect_overlay video_mixer_sva video_mixer_sva_m (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .in_hs_i      (vid_i.hs),
        .in_vs_i      (vid_i.vs),
        .in_de_i      (vid_i.de),
        .out_hs_i     (vid_o.hs),
        .out_vs_i     (vid_o.vs),
        .out_de_i     (vid_o.de),
        .pop_i        (pop_o),
        .fifo_empty_i (fifo_empty_i)
    );

    initial core_clk = 1'b0;
    always #2 core_clk = ~core_clk;

    ////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////
    // camera word is b in the top bits, then g, then r
    function automatic logic [15:0] swap_bgr(input logic [15:0] w);
        return {w[4:0], w[10:5], w[15:11]};
    endfunction

    function automatic logic [15:0] trunc_888(input logic [23:0] p);
        return {p[23:19], p[15:10], p[7:3]};
    endfunction

    function automatic logic [23:0] pad_565(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic bit in_window(input int line, input int col, input int left,
                                     input int top, input int width, input int height);
        return (col >= left) && (col < left + width) && (line >= top) && (line < top + height);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic build_tables();
        logic [31:0] r;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            r          = $random(seed);
            cam_hi[i]  = r[15:8];
            cam_lo[i]  = r[7:0];
            cam_exp[i] = swap_bgr(r[15:0]);
            r          = $random(seed);
            vin_pix[i] = r[23:0];
            vin_exp[i] = trunc_888(r[23:0]);
        end
    endtask

    ////////////////////////////////////////
    // source drivers
    ////////////////////////////////////////
    task automatic cam_cycle(input logic [7:0] d, input logic href, input logic vsync);
        @(posedge core_clk);
        cam_data_i  <= d;
        cam_href_i  <= href;
        cam_vsync_i <= vsync;
    endtask

    task automatic feed_camera();
        repeat (5) cam_cycle(8'h5a, 1'b1, 1'b0);  // odd junk run before the frame start
        repeat (2) cam_cycle(8'h00, 1'b0, 1'b0);
        repeat (2) cam_cycle(8'h00, 1'b0, 1'b1);  // frame start
        repeat (2) cam_cycle(8'h00, 1'b0, 1'b0);
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            cam_cycle(cam_hi[i], 1'b1, 1'b0);
            cam_cycle(cam_lo[i], 1'b1, 1'b0);
            if (i % 2 == 1)
                repeat (1 + (i / 2) % 2) cam_cycle(8'h00, 1'b0, 1'b0);  // href gap
        end
    endtask

    task automatic vin_cycle(input logic [23:0] p, input logic de, input logic vs);
        @(posedge core_clk);
        vin_r_i  <= p[23:16];
        vin_g_i  <= p[15:8];
        vin_b_i  <= p[7:0];
        vin_de_i <= de;
        vin_vs_i <= vs;
    endtask

    task automatic feed_video_in();
        repeat (3) vin_cycle(24'hff00ff, 1'b1, 1'b0);  // junk
        vin_cycle(24'h000000, 1'b0, 1'b0);
        vin_cycle(24'h000000, 1'b0, 1'b1);
        vin_cycle(24'h000000, 1'b0, 1'b0);
        for (int i = 0; i < N_ENTRIES; i++)
            vin_cycle(vin_pix[i], 1'b1, 1'b0);
        vin_cycle(24'h000000, 1'b0, 1'b0);
    endtask

    ////////////////////////////////////////
    // output monitoring
    ////////////////////////////////////////
    task automatic wait_active_lines(input int n);
        int   seen;
        logic de_prev;
        seen    = 0;
        de_prev = 1'b0;
        while (seen < n)
        begin
            @(negedge core_clk);
            if (de_prev && !de_o)
                seen++;
            de_prev = de_o;
        end
    endtask

    task automatic wait_vs_rise();
        logic vs_prev;
        logic rise;
        vs_prev = 1'b1;  // a vs already high does not count
        do
        begin
            @(negedge core_clk);
            rise    = !vs_prev && vs_o;
            vs_prev = vs_o;
        end while (!rise);
    endtask

    // one whole frame from the first sample with vs_o high
    task automatic check_frame();
        int          col;
        int          line;
        int          vs_cnt;
        int          hs_run;
        int          hs_runs;
        int          idx0;
        int          idx1;
        logic        de_prev;
        logic [15:0] want;
        col     = 0;
        line    = 0;
        vs_cnt  = 0;
        hs_run  = 0;
        hs_runs = 0;
        idx0    = 0;
        idx1    = 0;
        de_prev = 1'b0;
        repeat (FRAME_CYCLES)
        begin
            if (vs_o)
                vs_cnt++;
            if (hs_o)
                hs_run++;
            else if (hs_run != 0)
            begin
                check_value("hs_o pulse width", hs_run, `VM_H_SYNC_END - `VM_H_SYNC_START);
                hs_runs++;
                hs_run = 0;
            end
            if (de_o)
            begin
                if (in_window(line, col, `VM_WIN0_LEFT, `VM_WIN0_TOP,
                              `VM_WIN0_WIDTH, `VM_WIN0_HEIGHT))
                begin
                    want = cam_exp[idx0];
                    idx0++;
                end
                else if (in_window(line, col, `VM_WIN1_LEFT, `VM_WIN1_TOP,
                                   `VM_WIN1_WIDTH, `VM_WIN1_HEIGHT))
                begin
                    want = vin_exp[idx1];
                    idx1++;
                end
                else
                    want = pixel_pkg::BAR_COLORS[3'(col / BAR_W)];
                check_value($sformatf("rgb_o line %0d col %0d", line, col),
                            {8'h00, r_o, g_o, b_o}, {8'h00, pad_565(want)});
                col++;
            end
            else if (de_prev)
            begin
                check_value("de_o pixels per line", col, `VM_H_ACTIVE);
                line++;
                col = 0;
            end
            de_prev = de_o;
            @(negedge core_clk);
        end
        check_value("active lines per frame", line, `VM_V_ACTIVE);
        check_value("hs_o pulses per frame", hs_runs, `VM_V_TOTAL);
        check_value("vs_o cycles per frame", vs_cnt, `VM_H_TOTAL);  // one full line
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        int lead_cnt;
        seed        = 32'hc8f8;
        rst_n_i     = 1'b0;
        cam_data_i  = 8'h00;
        cam_href_i  = 1'b0;
        cam_vsync_i = 1'b0;
        vin_de_i    = 1'b0;
        vin_vs_i    = 1'b0;
        vin_r_i     = 8'h00;
        vin_g_i     = 8'h00;
        vin_b_i     = 8'h00;
        lead_cnt    = 0;
        build_tables();

        repeat (2)
        begin
            @(negedge core_clk);
            check_value("de_o in reset", {31'b0, de_o}, 32'd0);
            check_value("hs_o in reset", {31'b0, hs_o}, 32'd0);
            check_value("vs_o in reset", {31'b0, vs_o}, 32'd0);
        end
        @(posedge core_clk);
        rst_n_i <= 1'b1;

        do
        begin
            @(negedge core_clk);
            check_value("hs_o before first pixel", {31'b0, hs_o}, 32'd0);
            check_value("vs_o before first pixel", {31'b0, vs_o}, 32'd0);
            if (!de_o)
                lead_cnt++;
        end while (!de_o);
        // raster register plus two overlay stages
        check_value("de_o low cycles after reset", lead_cnt, 32'd3);

        // both windows of this frame are behind us before any data goes in
        wait_active_lines(`VM_WIN1_TOP + `VM_WIN1_HEIGHT);
        fork
            feed_camera();
            feed_video_in();
        join

        wait_vs_rise();
        check_frame();

        $display("Everything OK");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("timeout: no fully checked frame within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== video_mixer.f ====
+incdir+common
common/video_timing_pkg.sv
common/pixel_pkg.sv
common/video_if.sv
rtl/cam_byte_pack.sv
rtl/pixel_fifo.sv
rtl/raster_gen.sv
overlay/rect_overlay.sv
rtl/video_mixer_top.sv
tb/video_mixer_sva.sv
tb/video_mixer_tb.sv
